// File: verilog/me_cfg.svh
`ifndef ME_CFG_SVH
`define ME_CFG_SVH

// --------------------
// operand width
// --------------------
`define ME_WIDTH 32

// counts bit positions and the 2*ME_WIDTH doublings of the rou generator
`define ME_BIT_CNT_W 7

`endif

// File: verilog/me_pkg.sv
`include "me_cfg.svh"

package me_pkg;

    // one operand or result word
    typedef logic [`ME_WIDTH-1:0] me_word_t;

    // montgomery accumulator, two guard bits
    typedef logic [`ME_WIDTH+1:0] me_acc_t;

    // operand set captured while idle
    typedef struct packed {
        me_word_t x;
        me_word_t y;
        me_word_t m;
    } me_operands_t;

    // multiplier request, computes a*b/R mod m
    typedef struct packed {
        me_word_t a;
        me_word_t b;
        me_word_t m;
    } mm_req_t;

endpackage

// File: verilog/me_rou_gen.sv
`timescale 1ns/1ns
`include "me_cfg.svh"

module me_rou_gen (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             rou_start,
    input  me_pkg::me_word_t modulus,
    output me_pkg::me_word_t rou,
    output logic             rou_done
);
    import me_pkg::*;

    localparam logic [`ME_BIT_CNT_W-1:0] LAST_DBL = (`ME_BIT_CNT_W)'(2 * `ME_WIDTH - 1);

    logic                     busy;
    logic [`ME_BIT_CNT_W-1:0] dbl_cnt;
    logic [`ME_WIDTH:0]       dbl;
    logic [`ME_WIDTH:0]       dbl_red;

    // double, then fold back below m
    assign dbl     = {rou, 1'b0};
    assign dbl_red = (dbl >= {1'b0, modulus}) ? dbl - {1'b0, modulus} : dbl;

    // --------------------
    // doubling counter
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            dbl_cnt  <= '0;
            rou_done <= 1'b0;
        end else begin
            rou_done <= 1'b0;
            if (rou_start) begin
                busy    <= 1'b1;
                dbl_cnt <= '0;
            end else if (busy) begin
                dbl_cnt <= dbl_cnt + 1'b1;
                if (dbl_cnt == LAST_DBL) begin
                    busy     <= 1'b0;
                    rou_done <= 1'b1;
                end
            end
        end
    end

    // working value, ends as 2^(2*width) mod m
    always_ff @(posedge clk) begin
        if (rou_start) begin
            rou <= me_word_t'(1);
        end else if (busy) begin
            rou <= dbl_red[`ME_WIDTH-1:0];
        end
    end

    // modulus is held by the controller over the whole run
    a_rou_below_mod: assert property (@(posedge clk) disable iff (!rst_n)
        rou_done |-> (rou < modulus));

endmodule

// File: verilog/me_mont_mul.sv
`timescale 1ns/1ns
`include "me_cfg.svh"

module me_mont_mul (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             mm_start,
    input  me_pkg::mm_req_t  mm_req,
    output me_pkg::me_word_t mm_res,
    output logic             mm_done
);
    import me_pkg::*;

    localparam logic [`ME_BIT_CNT_W-1:0] LAST_ITER = (`ME_BIT_CNT_W)'(`ME_WIDTH);

    logic                     busy;
    logic [`ME_BIT_CNT_W-1:0] iter_cnt;
    me_word_t                 a_sh;
    me_acc_t                  acc;
    me_acc_t                  acc_first;
    me_acc_t                  acc_next;
    me_acc_t                  acc_red;

    // one radix-2 step: add b on the a bit, make even with m, halve
    function automatic me_acc_t mm_step(input me_acc_t  acc_in,
                                        input logic     a_bit,
                                        input me_word_t b_in,
                                        input me_word_t m_in);
        me_acc_t sum;
        sum = acc_in;
        if (a_bit) begin
            sum = sum + {2'b00, b_in};
        end
        if (sum[0]) begin
            sum = sum + {2'b00, m_in};
        end
        return sum >> 1;
    endfunction

    // first step runs on the start edge straight from the request
    assign acc_first = mm_step('0, mm_req.a[0], mm_req.b, mm_req.m);
    assign acc_next  = mm_step(acc, a_sh[0], mm_req.b, mm_req.m);

    // acc < 2m here, one subtraction is enough
    assign acc_red = (acc >= {2'b00, mm_req.m}) ? acc - {2'b00, mm_req.m} : acc;

    // --------------------
    // iteration control
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            iter_cnt <= '0;
            mm_done  <= 1'b0;
        end else begin
            mm_done <= 1'b0;
            if (mm_start) begin
                busy     <= 1'b1;
                iter_cnt <= (`ME_BIT_CNT_W)'(1);
            end else if (busy) begin
                if (iter_cnt == LAST_ITER) begin
                    busy    <= 1'b0;
                    mm_done <= 1'b1;
                end else begin
                    iter_cnt <= iter_cnt + 1'b1;
                end
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (mm_start) begin
            acc  <= acc_first;
            a_sh <= mm_req.a >> 1;
        end else if (busy) begin
            if (iter_cnt == LAST_ITER) begin
                mm_res <= acc_red[`ME_WIDTH-1:0];
            end else begin
                acc  <= acc_next;
                a_sh <= a_sh >> 1;
            end
        end
    end

    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        mm_start |-> !busy);

    a_res_reduced: assert property (@(posedge clk) disable iff (!rst_n)
        mm_done |-> (mm_res < mm_req.m));

endmodule

// File: verilog/me_ctrl.sv
`timescale 1ns/1ns
`include "me_cfg.svh"

module me_ctrl (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             me_start,
    input  logic             me_x_valid,
    input  logic             me_y_valid,
    input  logic             me_m_valid,
    input  me_pkg::me_word_t me_x,
    input  me_pkg::me_word_t me_y,
    input  me_pkg::me_word_t me_m,
    input  me_pkg::me_word_t rou,
    input  logic             rou_done,
    input  me_pkg::me_word_t mm_res,
    input  logic             mm_done,
    output me_pkg::me_word_t modulus,
    output logic             rou_start,
    output me_pkg::mm_req_t  mm_req,
    output logic             mm_start,
    output me_pkg::me_word_t me_result,
    output logic             me_valid,
    output logic             me_busy
);
    import me_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ROU,
        ST_TO_MONT,
        ST_LOAD_X,
        ST_SQUARE,
        ST_MULTIPLY,
        ST_FINAL
    } state_t;

    localparam logic [`ME_BIT_CNT_W-1:0] MSB_IDX = (`ME_BIT_CNT_W)'(`ME_WIDTH - 1);
    localparam me_word_t                 ONE     = me_word_t'(1);

    state_t                   state;
    logic [`ME_BIT_CNT_W-1:0] bit_cnt;
    me_operands_t             ops;
    me_word_t                 result;
    me_word_t                 result2;
    logic                     cur_bit;
    logic                     last_bit;

    assign modulus  = ops.m;
    assign cur_bit  = ops.y[bit_cnt[$clog2(`ME_WIDTH)-1:0]];
    assign last_bit = (bit_cnt == '0);

    // --------------------
    // multiplier operands
    // --------------------
    always_comb begin
        mm_req.m = ops.m;
        case (state)
            ST_TO_MONT: begin
                // into montgomery form: 1 * R
                mm_req.a = rou;
                mm_req.b = ONE;
            end
            ST_LOAD_X: begin
                mm_req.a = ops.x;
                mm_req.b = rou;
            end
            ST_SQUARE: begin
                mm_req.a = result;
                mm_req.b = result;
            end
            ST_MULTIPLY: begin
                mm_req.a = result;
                mm_req.b = result2;
            end
            default: begin
                // final step leaves montgomery form
                mm_req.a = result;
                mm_req.b = ONE;
            end
        endcase
    end

    // --------------------
    // exponent scan FSM
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            bit_cnt   <= '0;
            rou_start <= 1'b0;
            mm_start  <= 1'b0;
            me_valid  <= 1'b0;
            me_busy   <= 1'b0;
        end else begin
            rou_start <= 1'b0;
            mm_start  <= 1'b0;
            me_valid  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (me_start) begin
                        state     <= ST_ROU;
                        rou_start <= 1'b1;
                        me_busy   <= 1'b1;
                    end
                end
                ST_ROU: begin
                    if (rou_done) begin
                        state    <= ST_TO_MONT;
                        mm_start <= 1'b1;
                    end
                end
                ST_TO_MONT: begin
                    if (mm_done) begin
                        state    <= ST_LOAD_X;
                        mm_start <= 1'b1;
                    end
                end
                ST_LOAD_X: begin
                    if (mm_done) begin
                        state    <= ST_SQUARE;
                        bit_cnt  <= MSB_IDX;
                        mm_start <= 1'b1;
                    end
                end
                ST_SQUARE: begin
                    if (mm_done) begin
                        mm_start <= 1'b1;
                        if (cur_bit) begin
                            state <= ST_MULTIPLY;
                        end else if (last_bit) begin
                            state <= ST_FINAL;
                        end else begin
                            bit_cnt <= bit_cnt - 1'b1;
                        end
                    end
                end
                ST_MULTIPLY: begin
                    if (mm_done) begin
                        mm_start <= 1'b1;
                        if (last_bit) begin
                            state <= ST_FINAL;
                        end else begin
                            state   <= ST_SQUARE;
                            bit_cnt <= bit_cnt - 1'b1;
                        end
                    end
                end
                ST_FINAL: begin
                    if (mm_done) begin
                        state    <= ST_IDLE;
                        me_valid <= 1'b1;
                        me_busy  <= 1'b0;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // operand capture and intermediate words
    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            if (me_x_valid) begin
                ops.x <= me_x;
            end
            if (me_y_valid) begin
                ops.y <= me_y;
            end
            if (me_m_valid) begin
                ops.m <= me_m;
            end
        end
        if (mm_done) begin
            case (state)
                ST_LOAD_X: begin
                    result2 <= mm_res;
                end
                ST_FINAL: begin
                    me_result <= mm_res;
                end
                ST_TO_MONT, ST_SQUARE, ST_MULTIPLY: begin
                    result <= mm_res;
                end
                default: begin
                end
            endcase
        end
    end

    // montgomery reduction needs an odd modulus for the whole run
    a_mod_odd: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ST_IDLE && me_start) |=> modulus[0]);

endmodule

// File: verilog/me_top.sv
`timescale 1ns/1ns

module me_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             me_start,
    input  logic             me_x_valid,
    input  logic             me_y_valid,
    input  logic             me_m_valid,
    input  me_pkg::me_word_t me_x,
    input  me_pkg::me_word_t me_y,
    input  me_pkg::me_word_t me_m,
    output me_pkg::me_word_t me_result,
    output logic             me_valid,
    output logic             me_busy
);
    import me_pkg::*;

    // controller to rou generator
    me_word_t modulus;
    logic     rou_start;
    me_word_t rou;
    logic     rou_done;

    // controller to multiplier
    mm_req_t  mm_req;
    logic     mm_start;
    me_word_t mm_res;
    logic     mm_done;

    me_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .me_start   (me_start),
        .me_x_valid (me_x_valid),
        .me_y_valid (me_y_valid),
        .me_m_valid (me_m_valid),
        .me_x       (me_x),
        .me_y       (me_y),
        .me_m       (me_m),
        .rou        (rou),
        .rou_done   (rou_done),
        .mm_res     (mm_res),
        .mm_done    (mm_done),
        .modulus    (modulus),
        .rou_start  (rou_start),
        .mm_req     (mm_req),
        .mm_start   (mm_start),
        .me_result  (me_result),
        .me_valid   (me_valid),
        .me_busy    (me_busy)
    );

    me_rou_gen u_rou (
        .clk       (clk),
        .rst_n     (rst_n),
        .rou_start (rou_start),
        .modulus   (modulus),
        .rou       (rou),
        .rou_done  (rou_done)
    );

    me_mont_mul u_mm (
        .clk      (clk),
        .rst_n    (rst_n),
        .mm_start (mm_start),
        .mm_req   (mm_req),
        .mm_res   (mm_res),
        .mm_done  (mm_done)
    );

endmodule

// File: tb/tb_me_top.sv
`timescale 1ns/1ns
`include "me_cfg.svh"

module tb_me_top;
    import me_pkg::*;

    localparam int W         = `ME_WIDTH;
    localparam int TIMEOUT   = 4000;
    localparam int RAND_RUNS = 200;

    logic     clk;
    logic     rst_n;
    logic     me_start;
    logic     me_x_valid;
    logic     me_y_valid;
    logic     me_m_valid;
    me_word_t me_x;
    me_word_t me_y;
    me_word_t me_m;
    me_word_t me_result;
    logic     me_valid;
    logic     me_busy;

    // expected result handed to the compare process
    me_word_t exp_result;
    string    exp_name;
    logic     exp_pending;

    int   errors;
    int   runs;
    int   valid_cnt;
    logic aborted;

    me_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .me_start   (me_start),
        .me_x_valid (me_x_valid),
        .me_y_valid (me_y_valid),
        .me_m_valid (me_m_valid),
        .me_x       (me_x),
        .me_y       (me_y),
        .me_m       (me_m),
        .me_result  (me_result),
        .me_valid   (me_valid),
        .me_busy    (me_busy)
    );

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    // --------------------
    // reference model
    // --------------------
    // plain square and multiply with double width products
    function automatic me_word_t modexp_ref(input me_word_t x, input me_word_t y,
                                            input me_word_t m);
        logic [2*W-1:0] acc;
        logic [2*W-1:0] base;
        logic [2*W-1:0] modv;
        int             i;
        modv = {{W{1'b0}}, m};
        base = {{W{1'b0}}, x} % modv;
        acc  = (2*W)'(1) % modv;
        for (i = W - 1; i >= 0; i--) begin
            acc = (acc * acc) % modv;
            if (y[i]) begin
                acc = (acc * base) % modv;
            end
        end
        return acc[W-1:0];
    endfunction

    // --------------------
    // compare process
    // --------------------
    always @(negedge clk) begin
        if (me_valid === 1'b1) begin
            valid_cnt++;
            if (!exp_pending) begin
                errors++;
                $display("Error: me_valid pulsed with no run pending");
            end else begin
                if (me_result !== exp_result) begin
                    errors++;
                    $display("Error: %s expected %h actual %h", exp_name, exp_result, me_result);
                end
                exp_pending = 1'b0;
            end
        end
    end

    // --------------------
    // stimulus tasks
    // --------------------
    task automatic load_operands(input me_word_t x, input me_word_t y, input me_word_t m);
        @(negedge clk);
        me_x       = x;
        me_y       = y;
        me_m       = m;
        me_x_valid = 1'b1;
        me_y_valid = 1'b1;
        me_m_valid = 1'b1;
        @(negedge clk);
        me_x_valid = 1'b0;
        me_y_valid = 1'b0;
        me_m_valid = 1'b0;
    endtask

    // one run: start pulse, optional disturbance while busy, wait for me_valid
    task automatic start_and_wait(input string name, input me_word_t expected,
                                  input logic disturb);
        int   cyc;
        int   cnt_before;
        logic busy_dropped;
        logic busy_rose;
        exp_result   = expected;
        exp_name     = name;
        exp_pending  = 1'b1;
        cnt_before   = valid_cnt;
        busy_dropped = 1'b0;
        busy_rose    = 1'b0;
        runs++;
        @(negedge clk);
        me_start = 1'b1;
        @(negedge clk);
        me_start = 1'b0;
        if (me_busy !== 1'b1) begin
            errors++;
            $display("Error: %s me_busy expected 1 actual %b", name, me_busy);
        end
        cyc = 0;
        while (me_valid !== 1'b1 && cyc < TIMEOUT) begin
            if (me_busy !== 1'b1) begin
                busy_dropped = 1'b1;
            end
            // new operands and a second start, all while busy
            if (disturb && cyc == 5) begin
                me_x       = ~me_x;
                me_y       = ~me_y;
                me_m       = me_m ^ 32'h0000_0002;
                me_x_valid = 1'b1;
                me_y_valid = 1'b1;
                me_m_valid = 1'b1;
                me_start   = 1'b1;
            end
            if (disturb && cyc == 6) begin
                me_x_valid = 1'b0;
                me_y_valid = 1'b0;
                me_m_valid = 1'b0;
                me_start   = 1'b0;
            end
            @(negedge clk);
            cyc++;
        end
        if (busy_dropped) begin
            errors++;
            $display("Error: %s me_busy fell before me_valid", name);
        end
        if (me_valid !== 1'b1) begin
            errors++;
            aborted = 1'b1;
            $display("timeout: no me_valid within %0d cycles in run %s", TIMEOUT, name);
        end else begin
            @(negedge clk);
            if (me_valid !== 1'b0) begin
                errors++;
                $display("Error: %s me_valid after pulse expected 0 actual %b", name, me_valid);
            end
            if (me_busy !== 1'b0) begin
                errors++;
                $display("Error: %s me_busy after me_valid expected 0 actual %b", name, me_busy);
            end
            // a start kept from the busy phase would raise me_busy again
            if (disturb) begin
                cyc = 0;
                while (cyc < 200) begin
                    if (me_busy !== 1'b0) begin
                        busy_rose = 1'b1;
                    end
                    @(negedge clk);
                    cyc++;
                end
            end
            if (busy_rose) begin
                errors++;
                $display("Error: %s me_busy rose again with no new start", name);
            end
            if (valid_cnt - cnt_before != 1) begin
                errors++;
                $display("Error: %s me_valid count expected 1 actual %0d", name,
                         valid_cnt - cnt_before);
            end
        end
    endtask

    task automatic run_case(input string name, input me_word_t x, input me_word_t y,
                            input me_word_t m, input me_word_t expected, input logic disturb);
        if (!aborted) begin
            load_operands(x, y, m);
            start_and_wait(name, expected, disturb);
        end
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        int       i;
        me_word_t rx;
        me_word_t ry;
        me_word_t rm;
        rst_n       = 1'b0;
        me_start    = 1'b0;
        me_x_valid  = 1'b0;
        me_y_valid  = 1'b0;
        me_m_valid  = 1'b0;
        me_x        = '0;
        me_y        = '0;
        me_m        = '0;
        exp_result  = '0;
        exp_name    = "";
        exp_pending = 1'b0;
        errors      = 0;
        runs        = 0;
        valid_cnt   = 0;
        aborted     = 1'b0;
        void'($urandom(32'h62102728));

        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (me_valid !== 1'b0 || me_busy !== 1'b0) begin
            errors++;
            $display("Error: after_reset expected valid 0 busy 0 actual valid %b busy %b",
                     me_valid, me_busy);
        end

        // known vectors
        run_case("pow_2_10", 2, 10, 1000003, 1024, 1'b0);
        run_case("large_mod", 32'h1234_5678, 32'hDEAD_BEEF, 32'hFFFF_FFFB,
                 modexp_ref(32'h1234_5678, 32'hDEAD_BEEF, 32'hFFFF_FFFB), 1'b0);
        run_case("large_mod_top", 32'hFFFF_FFFA, 32'hFFFF_FFFF, 32'hFFFF_FFFB,
                 modexp_ref(32'hFFFF_FFFA, 32'hFFFF_FFFF, 32'hFFFF_FFFB), 1'b0);

        // edge exponents and bases
        run_case("y_zero", 32'h0000_BEEF, 0, 32'h0001_0001, 1, 1'b0);
        run_case("y_one", 32'h0000_BEEF, 1, 32'h0001_0001, 32'h0000_BEEF, 1'b0);
        run_case("x_zero", 0, 32'h1234_5678, 32'h0001_0001, 0, 1'b0);

        for (i = 0; i < RAND_RUNS; i++) begin
            rm = $urandom | 32'h1;
            if (rm < 3) begin
                rm = 3;
            end
            rx = $urandom % rm;
            ry = $urandom;
            run_case($sformatf("random_%0d", i), rx, ry, rm, modexp_ref(rx, ry, rm), 1'b0);
        end

        // strobes and a second start while busy
        run_case("busy_strobes", 32'h0BAD_CAFE, 32'h8001_0203, 32'hF123_4567,
                 modexp_ref(32'h0BAD_CAFE, 32'h8001_0203, 32'hF123_4567), 1'b1);

        repeat (5) @(negedge clk);
        $display("runs %0d, me_valid pulses %0d, errors %0d", runs, valid_cnt, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+verilog
verilog/me_pkg.sv
verilog/me_rou_gen.sv
verilog/me_mont_mul.sv
verilog/me_ctrl.sv
verilog/me_top.sv
tb/tb_me_top.sv

// File: run.sh
#!/bin/sh
# build and run the modexp testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_me_top -f all.f -o tb_me_top
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

sim_out=$(./obj_dir/tb_me_top)
status=$?
printf '%s\n' "$sim_out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "^Test completed successfully$"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
